// File: common/fc_pkg.sv
//====================
// FC layer package
// Layer sizes, activation scaling and bus structs
//====================

package fc_pkg;

  //====================
  // Layer geometry
  //====================
  // Memory address width
  localparam int ADDR_WIDTH = 19;
  // Bytes per read beat
  localparam int CHUNK_BYTES = 8;
  // Fixed input vector length
  localparam int VEC_BYTES = 32;
  // Read beats per weight row
  localparam int CHUNKS_PER_ROW = VEC_BYTES / CHUNK_BYTES;
  // Largest supported row count
  localparam int MAX_ROWS = 128;
  // Address step between biases
  localparam int BIAS_BYTES = 4;

  //====================
  // Activation
  //====================
  // Weight scale 7 plus ReLU factor 1
  localparam int LOG2_SCALE = 8;
  // Clip level of the output byte
  localparam int OUT_MAX = 255;

  //====================
  // Types
  //====================
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  // Holds 0..MAX_ROWS inclusive
  typedef logic [$clog2(MAX_ROWS):0] row_count_t;
  // Lane 0 sits in bits 7:0
  typedef logic [CHUNK_BYTES*8-1:0] chunk_t;
  typedef logic signed [31:0] bias_t;
  typedef logic signed [31:0] acc_t;
  typedef logic [7:0] out_byte_t;

  // Layer setup, stable from go until done
  typedef struct packed {
    addr_t      addr_x;
    addr_t      addr_w;
    addr_t      addr_b;
    addr_t      addr_z;
    row_count_t num_rows;
  } fc_cfg_t;

  // Read request, held until valid
  typedef struct packed {
    logic  req;
    addr_t addr;
  } rd_req_t;

  // Write request, held until ack
  typedef struct packed {
    logic      req;
    addr_t     addr;
    out_byte_t data;
  } wr_req_t;

endpackage

// File: design/fc_fetch_port.sv
//====================
// FC fetch port
// One read channel, request until valid, payload held until consumed
//====================

`timescale 1ns/1ns

module fc_fetch_port #(
  parameter type payload_t = fc_pkg::chunk_t
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start,
  input  fc_pkg::addr_t   addr,
  input  logic            consume,
  output fc_pkg::rd_req_t mem_req,
  input  logic            mem_valid,
  input  payload_t        mem_data,
  output logic            ready,
  output payload_t        payload
);

  logic          req_q;
  fc_pkg::addr_t addr_q;
  payload_t      payload_q;

  //====================
  // Handshake state
  //====================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_q <= 1'b0;
      ready <= 1'b0;
    end
    else
    begin
      // Request drops right after the valid beat
      if (start)
        req_q <= 1'b1;
      else if (mem_valid)
        req_q <= 1'b0;
      // Valid wins, a consume never lands on the same beat
      if (req_q && mem_valid)
        ready <= 1'b1;
      else if (consume)
        ready <= 1'b0;
    end
  end

  // Address and payload capture
  always_ff @(posedge clk)
  begin
    if (start)
      addr_q <= addr;
    if (req_q && mem_valid)
      payload_q <= mem_data;
  end

  assign mem_req = '{req: req_q, addr: addr_q};
  // Stays valid after consume, bias is read at row end
  assign payload = payload_q;

endmodule

// File: design/fc_sequencer.sv
//====================
// FC sequencer
// Row and chunk FSM, read address generation, busy and done
//====================

`timescale 1ns/1ns

module fc_sequencer (
  input  logic               clk,
  input  logic               rst_n,
  input  fc_pkg::fc_cfg_t    cfg,
  input  logic               go,
  output logic               start_pic,
  output logic               start_wgt,
  output logic               start_bias,
  output fc_pkg::addr_t      addr_pic,
  output fc_pkg::addr_t      addr_wgt,
  output fc_pkg::addr_t      addr_bias,
  input  logic               ready_pic,
  input  logic               ready_wgt,
  input  logic               ready_bias,
  output logic               consume,
  output logic               accumulate,
  output logic               first_chunk,
  output logic               row_end,
  output fc_pkg::row_count_t row_index,
  input  logic               write_done,
  output logic               busy,
  output logic               done
);

  typedef enum logic [1:0] {S_IDLE, S_FETCH, S_ACC, S_WRITE} state_t;

  state_t                                      state;
  logic [$clog2(fc_pkg::CHUNKS_PER_ROW)-1:0]   chunk_cnt;
  logic [$clog2(fc_pkg::CHUNKS_PER_ROW)-1:0]   tgt_chunk;
  fc_pkg::row_count_t                          row_cnt;
  fc_pkg::row_count_t                          tgt_row;
  fc_pkg::addr_t                               chunk_off;
  fc_pkg::addr_t                               row_w_off;
  fc_pkg::addr_t                               row_b_off;
  logic                                        last_chunk;
  logic                                        last_row;
  logic                                        chunk_ready;
  logic                                        start_all;

  // num_rows is taken as at least 1
  assign last_chunk = (chunk_cnt == fc_pkg::CHUNKS_PER_ROW - 1);
  assign last_row   = (row_cnt == cfg.num_rows - 1'b1);
  // Bias only arrives with chunk 0
  assign chunk_ready = ready_pic && ready_wgt && (ready_bias || chunk_cnt != '0);

  //====================
  // Next fetch target
  //====================
  always_comb
  begin
    tgt_chunk = chunk_cnt;
    tgt_row   = row_cnt;
    case (state)
      S_IDLE:
      begin
        tgt_chunk = '0;
        tgt_row   = '0;
      end
      S_ACC:   tgt_chunk = chunk_cnt + 1'b1;
      S_WRITE:
      begin
        tgt_chunk = '0;
        tgt_row   = row_cnt + 1'b1;
      end
      default: ;
    endcase
  end

  // Fetch launch on go, after a middle chunk, or after a row's ack
  assign start_all = (state == S_IDLE && go) ||
                     (state == S_ACC && !last_chunk) ||
                     (state == S_WRITE && write_done && !last_row);
  assign start_pic  = start_all;
  assign start_wgt  = start_all;
  assign start_bias = start_all && (tgt_chunk == '0);

  // Offsets: 8k for a chunk, 32r per weight row, 4r per bias
  assign chunk_off = fc_pkg::addr_t'(tgt_chunk) * fc_pkg::addr_t'(fc_pkg::CHUNK_BYTES);
  assign row_w_off = fc_pkg::addr_t'(tgt_row) * fc_pkg::addr_t'(fc_pkg::VEC_BYTES);
  assign row_b_off = fc_pkg::addr_t'(tgt_row) * fc_pkg::addr_t'(fc_pkg::BIAS_BYTES);
  assign addr_pic  = cfg.addr_x + chunk_off;
  assign addr_wgt  = cfg.addr_w + row_w_off + chunk_off;
  assign addr_bias = cfg.addr_b + row_b_off;

  //====================
  // Control FSM
  //====================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= S_IDLE;
      chunk_cnt <= '0;
      row_cnt   <= '0;
      done      <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        S_IDLE:
        begin
          if (go)
          begin
            state     <= S_FETCH;
            chunk_cnt <= tgt_chunk;
            row_cnt   <= tgt_row;
          end
        end
        S_FETCH:
        begin
          if (chunk_ready)
            state <= S_ACC;
        end
        S_ACC:
        begin
          if (last_chunk)
            state <= S_WRITE;
          else
          begin
            state     <= S_FETCH;
            chunk_cnt <= tgt_chunk;
          end
        end
        S_WRITE:
        begin
          // Ack of the last row ends the run
          if (write_done && last_row)
          begin
            state <= S_IDLE;
            done  <= 1'b1;
          end
          else if (write_done)
          begin
            state     <= S_FETCH;
            chunk_cnt <= tgt_chunk;
            row_cnt   <= tgt_row;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // One cycle per chunk in S_ACC
  assign accumulate  = (state == S_ACC);
  assign consume     = accumulate;
  assign first_chunk = accumulate && (chunk_cnt == '0);
  assign row_end     = accumulate && last_chunk;
  assign row_index   = row_cnt;
  assign busy        = (state != S_IDLE);

endmodule

// File: design/fc_dot_accum.sv
//====================
// FC dot product accumulator
// 8-lane unsigned by signed products, row sum, bias add
//====================

`timescale 1ns/1ns

module fc_dot_accum (
  input  logic           clk,
  input  logic           rst_n,
  input  fc_pkg::chunk_t pic_chunk,
  input  fc_pkg::chunk_t wgt_chunk,
  input  fc_pkg::bias_t  bias,
  input  logic           accumulate,
  input  logic           first_chunk,
  input  logic           row_end,
  output logic           sum_valid,
  output fc_pkg::acc_t   sum
);

  fc_pkg::acc_t dot_sum;
  fc_pkg::acc_t acc_q;
  fc_pkg::acc_t acc_next;

  //====================
  // Chunk dot product
  //====================
  always_comb
  begin
    logic signed [16:0] prod;
    dot_sum = '0;
    for (int i = 0; i < fc_pkg::CHUNK_BYTES; i++)
    begin
      // Data byte zero extended, weight byte signed
      prod    = $signed({1'b0, pic_chunk[i*8 +: 8]}) * $signed(wgt_chunk[i*8 +: 8]);
      dot_sum = dot_sum + fc_pkg::acc_t'(prod);
    end
  end

  // First chunk restarts the row
  assign acc_next = (first_chunk ? fc_pkg::acc_t'(0) : acc_q) + dot_sum;

  // Row sum and result
  always_ff @(posedge clk)
  begin
    if (accumulate)
      acc_q <= acc_next;
    if (row_end)
      sum <= acc_next + bias;
  end

  // Result flag, one cycle after row_end
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      sum_valid <= 1'b0;
    else
      sum_valid <= row_end;
  end

endmodule

// File: design/fc_result_writer.sv
//====================
// FC result writer
// Step and clip activation, one byte write per row
//====================

`timescale 1ns/1ns

module fc_result_writer (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               sum_valid,
  input  fc_pkg::acc_t       sum,
  input  fc_pkg::row_count_t row_index,
  input  fc_pkg::addr_t      addr_z,
  output fc_pkg::wr_req_t    wr,
  input  logic               wr_ack,
  output logic               write_done
);

  fc_pkg::acc_t      shifted;
  fc_pkg::out_byte_t act;
  logic              req_q;
  fc_pkg::addr_t     addr_q;
  fc_pkg::out_byte_t data_q;

  //====================
  // Activation
  //====================
  // Positive sums only, so a plain shift is enough
  assign shifted = sum >>> fc_pkg::LOG2_SCALE;

  always_comb
  begin
    if (sum <= 0)
      act = '0;
    else if (shifted > fc_pkg::OUT_MAX)
      act = fc_pkg::out_byte_t'(fc_pkg::OUT_MAX);
    else
      act = shifted[7:0];
  end

  //====================
  // Write handshake
  //====================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      req_q <= 1'b0;
    else if (sum_valid)
      req_q <= 1'b1;
    else if (wr_ack)
      req_q <= 1'b0;
  end

  // One output byte per row
  always_ff @(posedge clk)
  begin
    if (sum_valid)
    begin
      addr_q <= addr_z + fc_pkg::addr_t'(row_index);
      data_q <= act;
    end
  end

  assign wr         = '{req: req_q, addr: addr_q, data: data_q};
  assign write_done = req_q && wr_ack;

endmodule

// File: design/fc_top.sv
//====================
// FC layer top
// Three fetch ports, sequencer, dot product and writer
//====================

`timescale 1ns/1ns

module fc_top (
  input  logic            clk,
  input  logic            rst_n,
  input  fc_pkg::fc_cfg_t cfg,
  input  logic            go,
  output logic            done,
  output logic            busy,
  output fc_pkg::rd_req_t pic_req,
  input  logic            pic_valid,
  input  fc_pkg::chunk_t  pic_data,
  output fc_pkg::rd_req_t wgt_req,
  input  logic            wgt_valid,
  input  fc_pkg::chunk_t  wgt_data,
  output fc_pkg::rd_req_t bias_req,
  input  logic            bias_valid,
  input  fc_pkg::bias_t   bias_data,
  output fc_pkg::wr_req_t wr_req,
  input  logic            wr_ack
);

  logic               start_pic, start_wgt, start_bias;
  fc_pkg::addr_t      addr_pic, addr_wgt, addr_bias;
  logic               ready_pic, ready_wgt, ready_bias;
  fc_pkg::chunk_t     pic_chunk, wgt_chunk;
  fc_pkg::bias_t      bias_word;
  logic               consume, accumulate, first_chunk, row_end;
  fc_pkg::row_count_t row_index;
  logic               sum_valid, write_done;
  fc_pkg::acc_t       sum;

  //====================
  // Read channels
  //====================
  fc_fetch_port #(.payload_t(fc_pkg::chunk_t)) u_pic_port (
    .clk, .rst_n, .start(start_pic), .addr(addr_pic), .consume,
    .mem_req(pic_req), .mem_valid(pic_valid), .mem_data(pic_data),
    .ready(ready_pic), .payload(pic_chunk)
  );

  fc_fetch_port #(.payload_t(fc_pkg::chunk_t)) u_wgt_port (
    .clk, .rst_n, .start(start_wgt), .addr(addr_wgt), .consume,
    .mem_req(wgt_req), .mem_valid(wgt_valid), .mem_data(wgt_data),
    .ready(ready_wgt), .payload(wgt_chunk)
  );

  // Bias port, one word per row
  fc_fetch_port #(.payload_t(fc_pkg::bias_t)) u_bias_port (
    .clk, .rst_n, .start(start_bias), .addr(addr_bias), .consume,
    .mem_req(bias_req), .mem_valid(bias_valid), .mem_data(bias_data),
    .ready(ready_bias), .payload(bias_word)
  );

  //====================
  // Pipeline stages
  //====================
  fc_sequencer u_sequencer (
    .clk, .rst_n, .cfg, .go, .start_pic, .start_wgt, .start_bias,
    .addr_pic, .addr_wgt, .addr_bias, .ready_pic, .ready_wgt, .ready_bias,
    .consume, .accumulate, .first_chunk, .row_end, .row_index,
    .write_done, .busy, .done
  );

  fc_dot_accum u_dot_accum (
    .clk, .rst_n, .pic_chunk, .wgt_chunk, .bias(bias_word), .accumulate,
    .first_chunk, .row_end, .sum_valid, .sum
  );

  fc_result_writer u_result_writer (
    .clk, .rst_n, .sum_valid, .sum, .row_index, .addr_z(cfg.addr_z),
    .wr(wr_req), .wr_ack, .write_done
  );

endmodule

// File: test/fc_tb_clock.sv
//====================
// Testbench clock
// Free running clock, 40 ns period
//====================

`timescale 1ns/1ns

module fc_tb_clock #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  // Low at time zero, first rising edge at half a period
  initial
  begin
    clk = 1'b0;
    forever
      #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

// File: test/fc_props.sv
//====================
// FC handshake properties
// Read and write hold rules, done and idle checks
//====================

`timescale 1ns/1ns

module fc_props (
  input logic            clk,
  input logic            rst_n,
  input logic            busy,
  input logic            done,
  input fc_pkg::rd_req_t pic_req,
  input logic            pic_valid,
  input fc_pkg::rd_req_t wgt_req,
  input logic            wgt_valid,
  input fc_pkg::rd_req_t bias_req,
  input logic            bias_valid,
  input fc_pkg::wr_req_t wr_req,
  input logic            wr_ack
);

  // Read requests hold with their address until valid
  assert property (@(posedge clk) disable iff (!rst_n)
    pic_req.req && !pic_valid |=> pic_req.req && $stable(pic_req.addr))
    else $error("pic read request dropped before valid");
  assert property (@(posedge clk) disable iff (!rst_n)
    wgt_req.req && !wgt_valid |=> wgt_req.req && $stable(wgt_req.addr))
    else $error("weight read request dropped before valid");
  assert property (@(posedge clk) disable iff (!rst_n)
    bias_req.req && !bias_valid |=> bias_req.req && $stable(bias_req.addr))
    else $error("bias read request dropped before valid");

  // Write request, address and byte frozen until ack
  assert property (@(posedge clk) disable iff (!rst_n)
    wr_req.req && !wr_ack |=> wr_req.req && $stable(wr_req.addr) && $stable(wr_req.data))
    else $error("write request changed before ack");

  // Done only ends a busy run
  assert property (@(posedge clk) disable iff (!rst_n) done |-> $past(busy))
    else $error("done without busy in the previous cycle");

  // Idle block drives no memory traffic
  assert property (@(posedge clk) disable iff (!rst_n)
    !busy |-> !(pic_req.req || wgt_req.req || bias_req.req || wr_req.req))
    else $error("memory request while idle");

endmodule

// File: test/fc_tb.sv
//====================
// FC layer testbench
// Byte memory with random latency, directed layer tests
//====================

`timescale 1ns/1ns

module fc_tb;

  // Rows over all tests, sizes the timeout
  localparam int TOTAL_ROWS     = 14;
  localparam int TIMEOUT_CYCLES = TOTAL_ROWS * fc_pkg::CHUNKS_PER_ROW * 8 + 400;
  localparam int MEM_BYTES      = 1 << fc_pkg::ADDR_WIDTH;
  // Random layer, shared by the last two tests
  localparam fc_pkg::addr_t RAND_X = 19'h10000;
  localparam fc_pkg::addr_t RAND_W = 19'h11000;
  localparam fc_pkg::addr_t RAND_B = 19'h12000;

  logic              clk;
  logic              rst_n;
  fc_pkg::fc_cfg_t   cfg;
  logic              go;
  logic              done;
  logic              busy;
  fc_pkg::rd_req_t   pic_req;
  fc_pkg::rd_req_t   wgt_req;
  fc_pkg::rd_req_t   bias_req;
  logic              pic_valid;
  logic              wgt_valid;
  logic              bias_valid;
  fc_pkg::chunk_t    pic_data;
  fc_pkg::chunk_t    wgt_data;
  fc_pkg::bias_t     bias_data;
  fc_pkg::wr_req_t   wr_req;
  logic              wr_ack;

  // Memory model state
  fc_pkg::out_byte_t mem [MEM_BYTES];
  fc_pkg::rd_req_t   rd_reqs [3];
  logic [2:0]        rd_valid;
  logic [2:0]        rd_pend;
  int                rd_wait [3];
  logic              wr_pend;
  int                wr_wait;
  fc_pkg::addr_t     wr_addr_q [$];
  fc_pkg::out_byte_t wr_data_q [$];
  logic [31:0]       data_state;
  logic [31:0]       delay_state;
  int                cycle_count;

  fc_tb_clock #(.PERIOD_NS(40)) u_clock (.clk(clk));

  fc_top u_fc_top (
    .clk, .rst_n, .cfg, .go, .done, .busy,
    .pic_req, .pic_valid, .pic_data,
    .wgt_req, .wgt_valid, .wgt_data,
    .bias_req, .bias_valid, .bias_data,
    .wr_req, .wr_ack
  );

  bind fc_top fc_props u_props (
    .clk(clk), .rst_n(rst_n), .busy(busy), .done(done),
    .pic_req(pic_req), .pic_valid(pic_valid),
    .wgt_req(wgt_req), .wgt_valid(wgt_valid),
    .bias_req(bias_req), .bias_valid(bias_valid),
    .wr_req(wr_req), .wr_ack(wr_ack)
  );

  //====================
  // Random numbers
  //====================
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Memory latency of 1 to 4 cycles
  function automatic int next_delay();
    delay_state = lcg_next(delay_state);
    return 1 + int'(delay_state[17:16]);
  endfunction

  function automatic fc_pkg::out_byte_t next_data_byte();
    data_state = lcg_next(data_state);
    return data_state[23:16];
  endfunction

  //====================
  // Memory access
  //====================
  // Lane 0 from the lowest address
  function automatic fc_pkg::chunk_t read_chunk(input fc_pkg::addr_t a);
    fc_pkg::chunk_t c;
    for (int i = 0; i < fc_pkg::CHUNK_BYTES; i++)
      c[i*8 +: 8] = mem[a + fc_pkg::addr_t'(i)];
    return c;
  endfunction

  // Little endian 32-bit word
  function automatic fc_pkg::bias_t read_bias(input fc_pkg::addr_t a);
    return {mem[a + 19'd3], mem[a + 19'd2], mem[a + 19'd1], mem[a]};
  endfunction

  task automatic put_bias(input fc_pkg::addr_t a, input fc_pkg::bias_t b);
    for (int i = 0; i < 4; i++)
      mem[a + fc_pkg::addr_t'(i)] = b[i*8 +: 8];
  endtask

  // Expected output byte of one row, straight from the layer rule
  function automatic fc_pkg::out_byte_t reference_byte(input fc_pkg::fc_cfg_t layer,
                                                       input int row);
    fc_pkg::addr_t w_base;
    int            total;
    int            scaled;
    w_base = layer.addr_w + fc_pkg::addr_t'(row * fc_pkg::VEC_BYTES);
    total  = read_bias(layer.addr_b + fc_pkg::addr_t'(row * fc_pkg::BIAS_BYTES));
    for (int i = 0; i < fc_pkg::VEC_BYTES; i++)
      total += int'(mem[layer.addr_x + fc_pkg::addr_t'(i)]) *
               int'($signed(mem[w_base + fc_pkg::addr_t'(i)]));
    // Step at zero, scale down, clip
    if (total <= 0)
      return '0;
    scaled = total >>> fc_pkg::LOG2_SCALE;
    if (scaled > fc_pkg::OUT_MAX)
      return fc_pkg::out_byte_t'(fc_pkg::OUT_MAX);
    return fc_pkg::out_byte_t'(scaled);
  endfunction

  //====================
  // Checks
  //====================
  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_addr(input string name, input fc_pkg::addr_t got,
                            input fc_pkg::addr_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] t=%0t %s got 0x%05h expected 0x%05h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_byte(input string name, input fc_pkg::out_byte_t got,
                            input fc_pkg::out_byte_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // One write per row, in row order
  task automatic check_writes(input fc_pkg::fc_cfg_t layer,
                              input fc_pkg::out_byte_t expected [$]);
    if (wr_addr_q.size() != int'(layer.num_rows))
    begin
      $display("Expected %0d output writes but memory saw %0d",
               layer.num_rows, wr_addr_q.size());
      abort_run();
    end
    for (int r = 0; r < expected.size(); r++)
    begin
      check_addr("wr_req.addr", wr_addr_q[r], layer.addr_z + fc_pkg::addr_t'(r));
      check_byte("wr_req.data", wr_data_q[r], expected[r]);
    end
  endtask

  //====================
  // Memory model
  //====================
  always @(posedge clk)
  begin
    #1;
    rd_reqs[0] = pic_req;
    rd_reqs[1] = wgt_req;
    rd_reqs[2] = bias_req;
    for (int c = 0; c < 3; c++)
    begin
      // Valid lasts one cycle
      if (rd_valid[c])
        rd_valid[c] = 1'b0;
      else if (rd_pend[c])
      begin
        rd_wait[c]--;
        if (rd_wait[c] == 0)
        begin
          rd_valid[c] = 1'b1;
          rd_pend[c]  = 1'b0;
        end
      end
      else if (rd_reqs[c].req)
      begin
        rd_pend[c] = 1'b1;
        rd_wait[c] = next_delay();
      end
    end
    if (rd_valid[0])
      pic_data = read_chunk(pic_req.addr);
    if (rd_valid[1])
      wgt_data = read_chunk(wgt_req.addr);
    if (rd_valid[2])
      bias_data = read_bias(bias_req.addr);
    pic_valid  = rd_valid[0];
    wgt_valid  = rd_valid[1];
    bias_valid = rd_valid[2];
    // Write side, stored and logged at ack
    if (wr_ack)
      wr_ack = 1'b0;
    else if (wr_pend)
    begin
      wr_wait--;
      if (wr_wait == 0)
      begin
        wr_ack  = 1'b1;
        wr_pend = 1'b0;
        mem[wr_req.addr] = wr_req.data;
        wr_addr_q.push_back(wr_req.addr);
        wr_data_q.push_back(wr_req.data);
      end
    end
    else if (wr_req.req)
    begin
      wr_pend = 1'b1;
      wr_wait = next_delay();
    end
  end

  // Run limit
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES)
    begin
      $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  //====================
  // Layer run
  //====================
  // Go pulse, busy watch until done, then a quiet tail
  task automatic run_layer(input fc_pkg::fc_cfg_t layer, input logic retrigger);
    int   waited;
    logic prev_ack;
    wr_addr_q.delete();
    wr_data_q.delete();
    waited   = 0;
    prev_ack = 1'b0;
    @(posedge clk);
    #1;
    cfg = layer;
    go  = 1'b1;
    @(posedge clk);
    #1;
    go = 1'b0;
    @(negedge clk);
    while (!done)
    begin
      check_flag("busy", busy, 1'b1);
      prev_ack = wr_ack;
      @(posedge clk);
      #1;
      // Second go in mid run
      go = retrigger && (waited == 5);
      waited++;
      @(negedge clk);
    end
    check_flag("busy", busy, 1'b0);
    check_flag("wr_ack", prev_ack, 1'b1);
    // Single done pulse, no second run
    repeat (3)
    begin
      @(negedge clk);
      check_flag("done", done, 1'b0);
      check_flag("busy", busy, 1'b0);
    end
  endtask

  //====================
  // Directed tests
  //====================
  task automatic single_row_test();
    fc_pkg::fc_cfg_t   layer;
    fc_pkg::out_byte_t expected [$];
    $display("Single row with small values");
    layer = '{addr_x: 19'h00100, addr_w: 19'h01000, addr_b: 19'h04000,
              addr_z: 19'h06000, num_rows: 8'd1};
    for (int i = 0; i < fc_pkg::VEC_BYTES; i++)
    begin
      mem[layer.addr_x + fc_pkg::addr_t'(i)] = fc_pkg::out_byte_t'(i + 1);
      mem[layer.addr_w + fc_pkg::addr_t'(i)] = 8'd2;
    end
    put_bias(layer.addr_b, 32'sd100);
    // 2 * 528 + 100 = 1156, shifted gives 4
    expected.push_back(8'd4);
    run_layer(layer, 1'b0);
    check_writes(layer, expected);
  endtask

  task automatic negative_sum_test();
    fc_pkg::fc_cfg_t   layer;
    fc_pkg::out_byte_t expected [$];
    $display("Negative sums");
    // Same vector as the single row
    layer = '{addr_x: 19'h00100, addr_w: 19'h01100, addr_b: 19'h04100,
              addr_z: 19'h06100, num_rows: 8'd2};
    for (int i = 0; i < fc_pkg::VEC_BYTES; i++)
    begin
      mem[layer.addr_w + fc_pkg::addr_t'(i)]      = 8'hfd;
      mem[layer.addr_w + fc_pkg::addr_t'(32 + i)] = 8'h01;
    end
    // -1584 + 50, then 528 - 1000
    put_bias(layer.addr_b, 32'sd50);
    put_bias(layer.addr_b + 19'd4, -32'sd1000);
    expected.push_back(8'd0);
    expected.push_back(8'd0);
    run_layer(layer, 1'b0);
    check_writes(layer, expected);
  endtask

  task automatic saturation_test();
    fc_pkg::fc_cfg_t   layer;
    fc_pkg::out_byte_t expected [$];
    $display("Saturation and small sums");
    layer = '{addr_x: 19'h00200, addr_w: 19'h01200, addr_b: 19'h04200,
              addr_z: 19'h06200, num_rows: 8'd3};
    for (int i = 0; i < fc_pkg::VEC_BYTES; i++)
    begin
      mem[layer.addr_x + fc_pkg::addr_t'(i)]      = 8'd255;
      mem[layer.addr_w + fc_pkg::addr_t'(i)]      = 8'd127;
      mem[layer.addr_w + fc_pkg::addr_t'(32 + i)] = (i == 0) ? 8'd1 : 8'd0;
      mem[layer.addr_w + fc_pkg::addr_t'(64 + i)] = 8'd0;
    end
    put_bias(layer.addr_b, 32'sd0);
    put_bias(layer.addr_b + 19'd4, 32'sd45);
    put_bias(layer.addr_b + 19'd8, 32'sd1);
    // 1036320 clips, 300 gives 1, 1 gives 0
    expected.push_back(8'd255);
    expected.push_back(8'd1);
    expected.push_back(8'd0);
    run_layer(layer, 1'b0);
    check_writes(layer, expected);
  endtask

  task automatic multi_row_test();
    fc_pkg::fc_cfg_t   layer;
    fc_pkg::out_byte_t expected [$];
    $display("Six random rows");
    layer = '{addr_x: RAND_X, addr_w: RAND_W, addr_b: RAND_B,
              addr_z: 19'h13000, num_rows: 8'd6};
    for (int i = 0; i < fc_pkg::VEC_BYTES; i++)
      mem[RAND_X + fc_pkg::addr_t'(i)] = next_data_byte();
    for (int i = 0; i < 6 * fc_pkg::VEC_BYTES; i++)
      mem[RAND_W + fc_pkg::addr_t'(i)] = next_data_byte();
    // Biases around +-32k
    for (int r = 0; r < 6; r++)
    begin
      data_state = lcg_next(data_state);
      put_bias(RAND_B + fc_pkg::addr_t'(r * fc_pkg::BIAS_BYTES), $signed(data_state) >>> 16);
    end
    for (int r = 0; r < 6; r++)
      expected.push_back(reference_byte(layer, r));
    run_layer(layer, 1'b0);
    check_writes(layer, expected);
  endtask

  task automatic control_test();
    fc_pkg::fc_cfg_t   layer;
    fc_pkg::out_byte_t expected [$];
    $display("Busy, done and ignored go");
    layer = '{addr_x: RAND_X, addr_w: RAND_W, addr_b: RAND_B,
              addr_z: 19'h14000, num_rows: 8'd2};
    for (int r = 0; r < 2; r++)
      expected.push_back(reference_byte(layer, r));
    run_layer(layer, 1'b1);
    check_writes(layer, expected);
  endtask

  //====================
  // Main sequence
  //====================
  initial
  begin
    rst_n       = 1'b0;
    cfg         = '0;
    go          = 1'b0;
    pic_valid   = 1'b0;
    pic_data    = '0;
    wgt_valid   = 1'b0;
    wgt_data    = '0;
    bias_valid  = 1'b0;
    bias_data   = '0;
    wr_ack      = 1'b0;
    rd_valid    = '0;
    rd_pend     = '0;
    wr_pend     = 1'b0;
    wr_wait     = 0;
    data_state  = 32'h63fe;
    delay_state = 32'h63fe;
    cycle_count = 0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    single_row_test();
    negative_sum_test();
    saturation_test();
    multi_row_test();
    control_test();
    $display("Test OK");
    $finish;
  end

endmodule

// File: verilog.f
common/fc_pkg.sv
design/fc_fetch_port.sv
design/fc_sequencer.sv
design/fc_dot_accum.sv
design/fc_result_writer.sv
design/fc_top.sv
test/fc_tb_clock.sv
test/fc_props.sv
test/fc_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the FC layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module fc_tb -f verilog.f -Mdir obj_dir -o fc_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/fc_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit 1
fi

echo "Simulation finished cleanly"
exit 0
